/* rtl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [6:0]  pc_t;
    typedef logic [3:0]  reg_addr_t;

    typedef enum logic [3:0] {
        cond_eq = 4'd0,
        cond_ne = 4'd1,
        cond_cs = 4'd2,
        cond_cc = 4'd3,
        cond_mi = 4'd4,
        cond_pl = 4'd5,
        cond_al = 4'd14
    } cond_e;

    // arm data-processing encodings
    typedef enum logic [3:0] {
        op_and = 4'd0,
        op_eor = 4'd1,
        op_sub = 4'd2,
        op_add = 4'd4,
        op_cmp = 4'd10,
        op_orr = 4'd12,
        op_mov = 4'd13,
        op_mvn = 4'd15
    } opcode_e;

    // 2'b11 is undefined
    typedef enum logic [1:0] {
        class_data   = 2'b00,
        class_mem    = 2'b01,
        class_branch = 2'b10
    } class_e;

    typedef enum logic [1:0] {
        shift_lsl,
        shift_lsr,
        shift_asr,
        shift_ror
    } shift_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_orr,
        alu_eor,
        alu_pass_b,
        alu_not_b
    } alu_op_e;

    typedef enum logic [2:0] {
        stage_fetch,
        stage_fetch_wait,
        stage_decode,
        stage_execute,
        stage_memory,
        stage_memory_wait,
        stage_writeback
    } stage_e;

    // status register flag bits
    localparam int flag_n = 31;
    localparam int flag_z = 30;
    localparam int flag_c = 29;
    localparam int flag_v = 28;

endpackage : cpu_pkg

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::shift_e  shift_op,
    input  logic [4:0]       imm5,
    input  logic             use_shift,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t   result,
    output logic             n,
    output logic             z,
    output logic             c,
    output logic             v
);
    import cpu_pkg::*;

    word_t       shifted;
    word_t       b_eff;
    logic [63:0] rotated;
    logic [32:0] sum;
    logic        sub;

    assign rotated = {b, b} >> imm5;

    // amount 0 leaves b as is for every type
    always_comb begin
        shifted = b;
        if (use_shift) begin
            case (shift_op)
                shift_lsl: shifted = b << imm5;
                shift_lsr: shifted = b >> imm5;
                shift_asr: shifted = word_t'($signed(b) >>> imm5);
                default:   shifted = rotated[31:0];
            endcase
        end
    end

    // one adder, sub is a + ~b + 1
    assign sub   = (op == alu_sub);
    assign b_eff = sub ? ~shifted : shifted;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'd0, sub};

    always_comb begin
        c = 1'b0;
        v = 1'b0;
        case (op)
            alu_add, alu_sub: begin
                result = sum[31:0];
                c      = sum[32];
                v      = (a[31] == b_eff[31]) && (sum[31] != a[31]);
            end
            alu_and:    result = a & shifted;
            alu_orr:    result = a | shifted;
            alu_eor:    result = a ^ shifted;
            alu_pass_b: result = shifted;
            alu_not_b:  result = ~shifted;
            default:    result = '0;
        endcase
    end

    assign n = result[31];
    assign z = (result == '0);

endmodule : alu

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t a_addr,
    input  cpu_pkg::reg_addr_t b_addr,
    input  cpu_pkg::reg_addr_t s_addr,
    input  cpu_pkg::reg_addr_t dbg_addr,
    input  cpu_pkg::reg_addr_t w_addr,
    input  cpu_pkg::word_t     w_data,
    input  logic               w_en,
    output cpu_pkg::word_t     a_data,
    output cpu_pkg::word_t     b_data,
    output cpu_pkg::word_t     s_data,
    output cpu_pkg::word_t     dbg_data
);
    import cpu_pkg::*;

    word_t regs [16];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en) begin
            regs[w_addr] <= w_data;
        end
    end

    // combinational reads, s_data feeds store data
    assign a_data   = regs[a_addr];
    assign b_data   = regs[b_addr];
    assign s_data   = regs[s_addr];
    assign dbg_data = regs[dbg_addr];

endmodule : reg_file

/* rtl/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::pc_t       start_pc,
    input  cpu_pkg::reg_addr_t rn,
    input  cpu_pkg::reg_addr_t rm,
    input  cpu_pkg::reg_addr_t rd,
    input  cpu_pkg::shift_e    shift_op,
    input  logic [4:0]         imm5,
    input  logic [11:0]        imm12,
    input  cpu_pkg::word_t     imm_branch,
    input  cpu_pkg::alu_op_e   alu_op,
    input  logic               sel_b_imm,
    input  logic               sel_pc_branch,
    input  logic               sel_w_ldr,
    input  logic               en_operands,
    input  logic               en_result,
    input  logic               en_status,
    input  logic               w_en,
    input  logic               load_pc,
    input  logic               mem_w_en,
    input  cpu_pkg::word_t     ram_data2,
    input  cpu_pkg::reg_addr_t reg_addr,
    output cpu_pkg::pc_t       pc,
    output cpu_pkg::word_t     status,
    output cpu_pkg::pc_t       ram_addr2,
    output cpu_pkg::word_t     ram_in2,
    output cpu_pkg::word_t     reg_output
);
    import cpu_pkg::*;

    word_t a_q;
    word_t b_q;
    word_t result_q;
    word_t a_data;
    word_t b_data;
    word_t w_data;
    word_t alu_result;
    logic  n;
    logic  z;
    logic  c;
    logic  v;
    logic  arith;
    pc_t   branch_target;
    pc_t   pc_next;

    assign w_data = sel_w_ldr ? ram_data2 : result_q;

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .a_addr   (rn),
        .b_addr   (rm),
        .s_addr   (rd),
        .dbg_addr (reg_addr),
        .w_addr   (rd),
        .w_data   (w_data),
        .w_en     (w_en),
        .a_data   (a_data),
        .b_data   (b_data),
        .s_data   (ram_in2),
        .dbg_data (reg_output)
    );

    // register operands are shifted inside the alu
    alu u_alu (
        .a         (a_q),
        .b         (b_q),
        .shift_op  (shift_op),
        .imm5      (imm5),
        .use_shift (!sel_b_imm),
        .op        (alu_op),
        .result    (alu_result),
        .n         (n),
        .z         (z),
        .c         (c),
        .v         (v)
    );

    always_ff @(posedge clk) begin
        if (en_operands) begin
            a_q <= a_data;
            b_q <= sel_b_imm ? {20'd0, imm12} : b_data;
        end
        if (en_result) begin
            result_q <= alu_result;
        end
    end

    // logic ops leave c and v alone
    assign arith = (alu_op == alu_add) || (alu_op == alu_sub);

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
        end else if (en_status) begin
            status[flag_n] <= n;
            status[flag_z] <= z;
            if (arith) begin
                status[flag_c] <= c;
                status[flag_v] <= v;
            end
        end
    end

    // branch target relative to pc + 1, wraps in 7 bits
    assign branch_target = pc + 7'd1 + imm_branch[6:0];
    assign pc_next       = sel_pc_branch ? branch_target : pc + 7'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= start_pc;
        end else if (load_pc) begin
            pc <= pc_next;
        end
    end

    assign ram_addr2 = result_q[6:0];

    // store address was latched by the execute cycle just before
    a_store_addr: assert property (@(posedge clk) disable iff (reset)
        mem_w_en |-> $past(en_result));

endmodule : datapath

/* rtl/controller.sv */
`timescale 1ns/1ps

module controller (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::word_t     instr,
    input  cpu_pkg::word_t     status,
    input  cpu_pkg::pc_t       pc,
    output cpu_pkg::reg_addr_t rn,
    output cpu_pkg::reg_addr_t rm,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::shift_e    shift_op,
    output logic [4:0]         imm5,
    output logic [11:0]        imm12,
    output cpu_pkg::word_t     imm_branch,
    output cpu_pkg::alu_op_e   alu_op,
    output logic               sel_b_imm,
    output logic               sel_pc_branch,
    output logic               sel_w_ldr,
    output logic               en_operands,
    output logic               en_result,
    output logic               en_status,
    output logic               w_en,
    output logic               load_pc,
    output logic               mem_w_en,
    output logic               retired,
    output cpu_pkg::stage_e    stage
);
    import cpu_pkg::*;

    word_t   ir;
    cond_e   cond;
    opcode_e opcode;
    logic    is_data;
    logic    is_mem;
    logic    is_branch;
    logic    i_bit;
    logic    s_bit;
    logic    op_valid;
    logic    cond_pass;
    logic    cond_ok;
    stage_e  stage_next;

    // instruction fields
    assign cond       = cond_e'(ir[31:28]);
    assign is_data    = (ir[27:26] == class_data);
    assign is_mem     = (ir[27:26] == class_mem);
    assign is_branch  = (ir[27:26] == class_branch);
    assign i_bit      = ir[25];
    assign opcode     = opcode_e'(ir[24:21]);
    assign s_bit      = ir[20];
    assign rn         = ir[19:16];
    assign rd         = ir[15:12];
    assign rm         = ir[3:0];
    assign shift_op   = shift_e'(ir[6:5]);
    assign imm5       = ir[11:7];
    assign imm12      = ir[11:0];
    assign imm_branch = {{8{ir[23]}}, ir[23:0]};

    always_comb begin
        case (stage)
            stage_fetch:       stage_next = stage_fetch_wait;
            stage_fetch_wait:  stage_next = stage_decode;
            stage_decode:      stage_next = stage_execute;
            stage_execute:     stage_next = stage_memory;
            stage_memory:      stage_next = stage_memory_wait;
            stage_memory_wait: stage_next = stage_writeback;
            default:           stage_next = stage_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage   <= stage_fetch;
            retired <= 1'b0;
            cond_ok <= 1'b0;
        end else begin
            stage   <= stage_next;
            retired <= (stage == stage_writeback);
            // flags may change in execute, so hold the decode verdict
            if (stage == stage_decode) begin
                cond_ok <= cond_pass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage == stage_fetch_wait) begin
            ir <= instr;
        end
    end

    always_comb begin
        case (cond)
            cond_eq: cond_pass = status[flag_z];
            cond_ne: cond_pass = !status[flag_z];
            cond_cs: cond_pass = status[flag_c];
            cond_cc: cond_pass = !status[flag_c];
            cond_mi: cond_pass = status[flag_n];
            cond_pl: cond_pass = !status[flag_n];
            cond_al: cond_pass = 1'b1;
            default: cond_pass = 1'b0;
        endcase
    end

    // opcode to alu function, memory ops add the offset
    always_comb begin
        op_valid = 1'b1;
        case (opcode)
            op_and:  alu_op = alu_and;
            op_eor:  alu_op = alu_eor;
            op_sub:  alu_op = alu_sub;
            op_add:  alu_op = alu_add;
            op_cmp:  alu_op = alu_sub;
            op_orr:  alu_op = alu_orr;
            op_mov:  alu_op = alu_pass_b;
            op_mvn:  alu_op = alu_not_b;
            default: begin
                alu_op   = alu_add;
                op_valid = 1'b0;
            end
        endcase
        if (!is_data) begin
            alu_op = alu_add;
        end
    end

    assign sel_b_imm     = is_mem || i_bit;
    assign sel_pc_branch = is_branch && cond_ok;
    assign sel_w_ldr     = is_mem;

    assign en_operands = (stage == stage_decode) && cond_pass;
    assign en_result   = (stage == stage_execute) && cond_ok && (is_data || is_mem);
    // cmp always sets flags
    assign en_status   = (stage == stage_execute) && cond_ok && is_data && op_valid
                         && (s_bit || opcode == op_cmp);
    assign mem_w_en    = (stage == stage_memory) && cond_ok && is_mem && !s_bit;
    assign load_pc     = (stage == stage_writeback);
    assign w_en        = (stage == stage_writeback) && cond_ok
                         && ((is_data && op_valid && opcode != op_cmp) || (is_mem && s_bit));

    a_store_stage: assert property (@(posedge clk) disable iff (reset)
        mem_w_en |-> stage == stage_memory);

    a_write_stage: assert property (@(posedge clk) disable iff (reset)
        w_en |-> stage == stage_writeback);

    a_legal_stage: assert property (@(posedge clk) disable iff (reset)
        stage inside {stage_fetch, stage_fetch_wait, stage_decode, stage_execute,
                      stage_memory, stage_memory_wait, stage_writeback});

    // pc in the datapath moves only after a writeback
    a_pc_hold: assert property (@(posedge clk) disable iff (reset)
        !load_pc |=> $stable(pc));

endmodule : controller

/* rtl/cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::word_t     instr,
    input  cpu_pkg::word_t     ram_data2,
    input  cpu_pkg::pc_t       start_pc,
    input  cpu_pkg::reg_addr_t reg_addr,
    output logic               mem_w_en,
    output cpu_pkg::pc_t       ram_addr2,
    output cpu_pkg::word_t     ram_in2,
    output cpu_pkg::word_t     status,
    output cpu_pkg::pc_t       pc,
    output logic               load_pc,
    output cpu_pkg::stage_e    stage,
    output logic               retired,
    output cpu_pkg::word_t     reg_output
);
    import cpu_pkg::*;

    // controller to datapath
    reg_addr_t   rn;
    reg_addr_t   rm;
    reg_addr_t   rd;
    shift_e      shift_op;
    logic [4:0]  imm5;
    logic [11:0] imm12;
    word_t       imm_branch;
    alu_op_e     alu_op;
    logic        sel_b_imm;
    logic        sel_pc_branch;
    logic        sel_w_ldr;
    logic        en_operands;
    logic        en_result;
    logic        en_status;
    logic        w_en;

    datapath u_datapath (
        .clk           (clk),
        .reset         (reset),
        .start_pc      (start_pc),
        .rn            (rn),
        .rm            (rm),
        .rd            (rd),
        .shift_op      (shift_op),
        .imm5          (imm5),
        .imm12         (imm12),
        .imm_branch    (imm_branch),
        .alu_op        (alu_op),
        .sel_b_imm     (sel_b_imm),
        .sel_pc_branch (sel_pc_branch),
        .sel_w_ldr     (sel_w_ldr),
        .en_operands   (en_operands),
        .en_result     (en_result),
        .en_status     (en_status),
        .w_en          (w_en),
        .load_pc       (load_pc),
        .mem_w_en      (mem_w_en),
        .ram_data2     (ram_data2),
        .reg_addr      (reg_addr),
        .pc            (pc),
        .status        (status),
        .ram_addr2     (ram_addr2),
        .ram_in2       (ram_in2),
        .reg_output    (reg_output)
    );

    controller u_controller (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .status        (status),
        .pc            (pc),
        .rn            (rn),
        .rm            (rm),
        .rd            (rd),
        .shift_op      (shift_op),
        .imm5          (imm5),
        .imm12         (imm12),
        .imm_branch    (imm_branch),
        .alu_op        (alu_op),
        .sel_b_imm     (sel_b_imm),
        .sel_pc_branch (sel_pc_branch),
        .sel_w_ldr     (sel_w_ldr),
        .en_operands   (en_operands),
        .en_result     (en_result),
        .en_status     (en_status),
        .w_en          (w_en),
        .load_pc       (load_pc),
        .mem_w_en      (mem_w_en),
        .retired       (retired),
        .stage         (stage)
    );

endmodule : cpu

/* tests/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int num_retire  = 300;
    localparam int cycle_limit = num_retire * 7 + 100;

    logic      clk;
    logic      reset;
    word_t     instr;
    word_t     ram_data2;
    pc_t       start_pc;
    reg_addr_t reg_addr;
    logic      mem_w_en;
    pc_t       ram_addr2;
    word_t     ram_in2;
    word_t     status;
    pc_t       pc;
    logic      load_pc;
    stage_e    stage;
    logic      retired;
    word_t     reg_output;

    // memories on the DUT side
    word_t imem [128];
    word_t dmem [128];

    // reference model state
    word_t m_regs [16];
    word_t m_dmem [128];
    word_t m_status;
    pc_t   m_pc;

    cpu u_dut (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .ram_data2  (ram_data2),
        .start_pc   (start_pc),
        .reg_addr   (reg_addr),
        .mem_w_en   (mem_w_en),
        .ram_addr2  (ram_addr2),
        .ram_in2    (ram_in2),
        .status     (status),
        .pc         (pc),
        .load_pc    (load_pc),
        .stage      (stage),
        .retired    (retired),
        .reg_output (reg_output)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_stage(input string name, input stage_e got, input stage_e exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %s, expected %s", $time, name,
                     got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic opcode_e valid_opcode(input logic [2:0] k);
        case (k)
            3'd0:    return op_and;
            3'd1:    return op_eor;
            3'd2:    return op_sub;
            3'd3:    return op_add;
            3'd4:    return op_cmp;
            3'd5:    return op_orr;
            3'd6:    return op_mov;
            default: return op_mvn;
        endcase
    endfunction

    function automatic word_t random_instr();
        word_t       r;
        word_t       ins;
        int unsigned pick;
        int          off;

        r    = $urandom();
        ins  = $urandom();
        pick = $urandom_range(0, 99);
        // codes 0 to 5 are eq..pl and the rest become al
        ins[31:28] = (r[2:0] <= 3'd5) ? {1'b0, r[2:0]} : 4'd14;
        if (r[4:3] == 2'b00) begin
            ins[31:28] = 4'd14;
        end
        if (pick < 50) begin
            ins[27:26] = class_data;
            // a few keep a raw opcode that may be undefined
            if (pick >= 3) begin
                ins[24:21] = valid_opcode(r[7:5]);
            end
        end else if (pick < 78) begin
            ins[27:26] = class_mem;
        end else if (pick < 96) begin
            ins[27:26] = class_branch;
            off = int'($urandom_range(0, 9)) - 3;
            if (off == -1) begin
                off = 2;
            end
            ins[23:0] = 24'(off);
        end else begin
            ins[27:26] = 2'b11;
        end
        return ins;
    endfunction

    function automatic word_t shift_operand(input word_t value, input logic [1:0] kind,
                                            input logic [4:0] amount);
        word_t out;

        if (amount == 5'd0) begin
            out = value;
        end else begin
            case (kind)
                2'd0:    out = value << amount;
                2'd1:    out = value >> amount;
                2'd2:    out = (value >> amount)
                               | ({32{value[31]}} << (6'd32 - {1'b0, amount}));
                default: out = (value >> amount) | (value << (6'd32 - {1'b0, amount}));
            endcase
        end
        return out;
    endfunction

    function automatic logic cond_holds(input logic [3:0] code, input word_t flags);
        case (code)
            4'd0:    return flags[flag_z];
            4'd1:    return !flags[flag_z];
            4'd2:    return flags[flag_c];
            4'd3:    return !flags[flag_c];
            4'd4:    return flags[flag_n];
            4'd5:    return !flags[flag_n];
            4'd14:   return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // one instruction of the reference model
    task automatic model_step(output logic st_exp, output pc_t st_addr, output word_t st_data);
        word_t       ins;
        logic        pass;
        word_t       a;
        word_t       b;
        word_t       res;
        logic [32:0] wide;
        logic        c_out;
        logic        v_out;
        logic        arith;
        logic        known;
        opcode_e     opc;
        reg_addr_t   rd_i;

        ins     = imem[m_pc];
        st_exp  = 1'b0;
        st_addr = '0;
        st_data = '0;
        pass    = cond_holds(ins[31:28], m_status);
        rd_i    = ins[15:12];
        a       = m_regs[ins[19:16]];
        opc     = opcode_e'(ins[24:21]);
        if (pass && ins[27:26] == class_data) begin
            b = ins[25] ? {20'd0, ins[11:0]}
                        : shift_operand(m_regs[ins[3:0]], ins[6:5], ins[11:7]);
            known = 1'b1;
            arith = 1'b0;
            c_out = 1'b0;
            v_out = 1'b0;
            res   = '0;
            case (opc)
                op_and: res = a & b;
                op_eor: res = a ^ b;
                op_sub, op_cmp: begin
                    res   = a - b;
                    arith = 1'b1;
                    c_out = (a >= b);
                    v_out = (a[31] != b[31]) && (res[31] != a[31]);
                end
                op_add: begin
                    wide  = {1'b0, a} + {1'b0, b};
                    res   = wide[31:0];
                    arith = 1'b1;
                    c_out = wide[32];
                    v_out = (a[31] == b[31]) && (res[31] != a[31]);
                end
                op_orr:  res = a | b;
                op_mov:  res = b;
                op_mvn:  res = ~b;
                default: known = 1'b0;
            endcase
            if (known) begin
                if (ins[20] || opc == op_cmp) begin
                    m_status[flag_n] = res[31];
                    m_status[flag_z] = (res == '0);
                    if (arith) begin
                        m_status[flag_c] = c_out;
                        m_status[flag_v] = v_out;
                    end
                end
                if (opc != op_cmp) begin
                    m_regs[rd_i] = res;
                end
            end
        end else if (pass && ins[27:26] == class_mem) begin
            res = a + {20'd0, ins[11:0]};
            if (ins[20]) begin
                m_regs[rd_i] = m_dmem[res[6:0]];
            end else begin
                m_dmem[res[6:0]] = m_regs[rd_i];
                st_exp  = 1'b1;
                st_addr = res[6:0];
                st_data = m_regs[rd_i];
            end
        end
        if (pass && ins[27:26] == class_branch) begin
            m_pc = m_pc + 7'd1 + ins[6:0];
        end else begin
            m_pc = m_pc + 7'd1;
        end
    endtask

    initial begin
        word_t      seen_data;
        pc_t        seen_addr;
        logic       store_seen;
        logic       write_pending;
        logic       st_exp;
        pc_t        st_addr;
        word_t      st_data;
        word_t      r;
        logic [2:0] stage_idx;
        int         cycles;
        int         since_retire;
        int         retire_count;

        reset     = 1'b1;
        instr     = '0;
        ram_data2 = '0;
        reg_addr  = '0;
        start_pc  = '0;
        void'($urandom(32'hb326_d0d7));

        for (int i = 0; i < 128; i++) begin
            imem[7'(i)]   = random_instr();
            dmem[7'(i)]   = (word_t'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
            m_dmem[7'(i)] = dmem[7'(i)];
        end
        for (int i = 0; i < 16; i++) begin
            m_regs[4'(i)] = '0;
        end
        r        = $urandom();
        start_pc = r[6:0];
        m_pc     = r[6:0];
        m_status = '0;
        instr    = imem[start_pc];

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_pc("pc", pc, start_pc);
        check_stage("stage", stage, stage_fetch);
        check_word("status", status, '0);
        check_bit("retired", retired, 1'b0);
        check_bit("mem_w_en", mem_w_en, 1'b0);
        check_bit("load_pc", load_pc, 1'b0);
        reset = 1'b0;

        seen_data     = '0;
        seen_addr     = '0;
        store_seen    = 1'b0;
        write_pending = 1'b0;
        stage_idx     = 3'd0;
        cycles        = 0;
        since_retire  = 0;
        retire_count  = 0;

        while (retire_count < num_retire) begin
            @(posedge clk);
            if (write_pending) begin
                dmem[seen_addr] = seen_data;
                write_pending   = 1'b0;
            end
            @(negedge clk);
            cycles++;
            since_retire++;
            if (cycles > cycle_limit) begin
                $display("ERROR: timeout after %0d cycles with %0d instructions retired",
                         cycles, retire_count);
                $display("Done: errors found");
                $fatal(1, "timeout");
            end
            stage_idx = (stage_idx == 3'd6) ? 3'd0 : stage_idx + 3'd1;
            check_stage("stage", stage, stage_e'(stage_idx));
            check_bit("load_pc", load_pc, stage_idx == 3'd6);
            check_bit("retired", retired, since_retire == 7);

            if (retired) begin
                model_step(st_exp, st_addr, st_data);
                if (st_exp && !store_seen) begin
                    report_problem("a store passed its condition but mem_w_en never pulsed");
                end
                if (!st_exp && store_seen) begin
                    report_problem("mem_w_en pulsed for an instruction that does not store");
                end
                if (st_exp) begin
                    check_pc("ram_addr2", seen_addr, st_addr);
                    check_word("ram_in2", seen_data, st_data);
                end
                check_pc("pc", pc, m_pc);
                check_word("status", status, m_status);
                check_word("reg_output", reg_output, m_regs[reg_addr]);
                store_seen   = 1'b0;
                since_retire = 0;
                retire_count++;
            end

            if (mem_w_en) begin
                if (stage_idx != 3'd4) begin
                    report_problem("mem_w_en pulsed outside the memory stage");
                end
                store_seen    = 1'b1;
                write_pending = 1'b1;
                seen_addr     = ram_addr2;
                seen_data     = ram_in2;
            end

            // inputs change on the falling edge
            r         = $urandom();
            instr     = imem[pc];
            ram_data2 = dmem[ram_addr2];
            reg_addr  = r[3:0];
        end

        $display("Done: no errors");
        $finish;
    end

endmodule : cpu_tb

/* cpu.f */
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/datapath.sv
rtl/controller.sv
rtl/cpu.sv
tests/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= cpu_tb
FILELIST  ?= cpu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
